//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= rr_record_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/rr_csrs.sv
`timescale 1ns/1ps
`include "rr_macros.svh"

module rr_csrs (
    input  logic                    clk,
    input  logic                    rstn,
    input  rr_pkg::axil_req_t       axil_req,
    output rr_pkg::axil_rsp_t       axil_rsp,
    output rr_pkg::storage_csr_t    storage_csr,
    output rr_pkg::mode_csr_t       mode_csr,
    input  logic [`RR_TRACE_AW:0]   trace_count,
    output logic [`RR_TRACE_AW-1:0] trace_rd_idx,
    input  rr_pkg::trace_word_t     trace_rd_word
);

    logic [31:0] csrs [`RR_CSR_CNT];

    logic awready;
    logic wready;
    logic bvalid;
    logic arready;
    logic rvalid;
    logic [31:0] rdata;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic b_busy;
    logic write_fire;
    logic aw_handled;
    logic w_handled;

    logic [`RR_CSR_ADDR_WIDTH-1:0] wr_idx;
    logic [`RR_CSR_ADDR_WIDTH-1:0] wr_idx_q;
    logic [31:0] wr_data;
    logic [31:0] wr_mask;
    logic [31:0] merge_base;
    logic [31:0] merged;
    logic commit_q;
    logic commit_qq;
    logic wr_allowed;

    logic [`RR_CSR_ADDR_WIDTH-1:0] rd_idx;
    logic ar_hs;
    logic r_hs;
    logic r_busy;

    assign aw_hs = axil_req.awvalid & awready;
    assign w_hs = axil_req.wvalid & wready;
    assign b_hs = bvalid & axil_req.bready;
    assign b_busy = bvalid & ~axil_req.bready;

    // Both halves of a write are in once each channel is either accepted now or held
    assign write_fire = (aw_hs | aw_handled) & (w_hs | w_handled);

    assign awready = ~aw_handled & ~b_busy;
    assign wready = ~w_handled & ~b_busy;

    always_ff @(posedge clk) begin
        if (~rstn) begin
            aw_handled <= 1'b0;
            w_handled <= 1'b0;
            bvalid <= 1'b0;
            commit_q <= 1'b0;
            commit_qq <= 1'b0;
        end else begin
            if (write_fire) begin
                aw_handled <= 1'b0;
                w_handled <= 1'b0;
            end else begin
                if (aw_hs) begin
                    aw_handled <= 1'b1;
                end
                if (w_hs) begin
                    w_handled <= 1'b1;
                end
            end
            if (write_fire) begin
                bvalid <= 1'b1;
            end else if (b_hs) begin
                bvalid <= 1'b0;
            end
            commit_q <= write_fire;
            commit_qq <= commit_q;
        end
    end

    // A commit still in flight to the same register forwards its merged value
    assign merge_base = (commit_qq && wr_idx_q == wr_idx) ? merged : csrs[wr_idx];

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_idx <= axil_req.awaddr[2 +: `RR_CSR_ADDR_WIDTH];
        end
        if (w_hs) begin
            wr_data <= axil_req.wdata;
            for (int i = 0; i < 4; i++) begin
                wr_mask[8*i +: 8] <= {8{axil_req.wstrb[i]}};
            end
        end
        wr_idx_q <= wr_idx;
        if (commit_q) begin
            merged <= (wr_mask & wr_data) | (~wr_mask & merge_base);
        end
    end

    // Status and window registers are driven from live inputs
    assign wr_allowed = (wr_idx_q != `TRACE_COUNT) && (wr_idx_q != `TRACE_WORD);

    always_ff @(posedge clk) begin
        if (~rstn) begin
            for (int i = 0; i < `RR_CSR_CNT; i++) begin
                csrs[i] <= 32'h0;
            end
        end else if (commit_qq && wr_allowed) begin
            csrs[wr_idx_q] <= merged;
        end
    end

    // Reads wait for pending commits so they never see stale data
    assign r_busy = rvalid & ~axil_req.rready;
    assign arready = ~r_busy & ~commit_q & ~commit_qq;
    assign ar_hs = axil_req.arvalid & arready;
    assign r_hs = rvalid & axil_req.rready;
    assign rd_idx = axil_req.araddr[2 +: `RR_CSR_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (~rstn) begin
            rvalid <= 1'b0;
        end else if (ar_hs) begin
            rvalid <= 1'b1;
        end else if (r_hs) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (rd_idx)
                `TRACE_COUNT: rdata <= 32'(trace_count);
                `TRACE_WORD:  rdata <= trace_rd_word;
                default:      rdata <= csrs[rd_idx];
            endcase
        end
    end

    assign axil_rsp = '{
        awready: awready,
        wready:  wready,
        bvalid:  bvalid,
        bresp:   2'b00,
        arready: arready,
        rvalid:  rvalid,
        rdata:   rdata,
        rresp:   2'b00
    };

    assign storage_csr = '{
        buf_addr:            csrs[`BUF_ADDR_LO][`RR_TRACE_AW-1:0],
        buf_size:            csrs[`BUF_SIZE_LO][`RR_TRACE_AW:0],
        write_buf_update:    commit_q && (wr_idx == `WRITE_BUF_UPDATE),
        record_force_finish: commit_q && (wr_idx == `RECORD_FORCE_FINISH)
    };

    assign mode_csr = '{
        record_en: csrs[`RR_MODE][0],
        replay_en: csrs[`RR_MODE][1]
    };

    assign trace_rd_idx = csrs[`TRACE_IDX][`RR_TRACE_AW-1:0];

endmodule

//--- hdl/rr_log_packer.sv
`timescale 1ns/1ps

module rr_log_packer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                record_en,
    input  logic                flush,
    input  rr_pkg::log_entry_t  in_entry,
    input  logic                in_valid,
    output logic                in_ready,
    output rr_pkg::trace_word_t out_word,
    output logic                out_valid,
    input  logic                out_ready
);

    rr_pkg::log_entry_t half_entry;
    logic half_valid;
    logic out_free;
    logic take;
    logic flush_pend;
    logic flush_req;
    logic flush_do;

    assign out_free = ~out_valid | out_ready;
    assign in_ready = out_free;

    // With recording off, entries are consumed and thrown away
    assign take = in_valid & in_ready & record_en;

    // A flush that meets a busy output slot or a new entry waits a cycle
    assign flush_req = flush | flush_pend;
    assign flush_do = flush_req & out_free & ~take;

    always_ff @(posedge clk) begin
        if (~rstn) begin
            half_valid <= 1'b0;
            out_valid <= 1'b0;
            flush_pend <= 1'b0;
        end else begin
            flush_pend <= flush_req & ~flush_do;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                half_valid <= ~half_valid;
                if (half_valid) begin
                    out_valid <= 1'b1;
                end
            end else if (flush_do && half_valid) begin
                half_valid <= 1'b0;
                out_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !half_valid) begin
            half_entry <= in_entry;
        end
        if (take && half_valid) begin
            out_word <= '{hi: in_entry, lo: half_entry};
        end else if (flush_do && half_valid) begin
            out_word <= '{hi: rr_pkg::pad_entry, lo: half_entry};
        end
    end

endmodule

//--- hdl/rr_macros.svh
`ifndef RR_MACROS_SVH
`define RR_MACROS_SVH

// Register file geometry
`define RR_CSR_CNT          16
`define RR_CSR_ADDR_WIDTH   4

// Trace memory holds 2**RR_TRACE_AW words of 32 bits
`define RR_TRACE_AW         6

// Register indices, byte address is index times 4
`define RR_MODE             0
`define BUF_ADDR_LO         1
`define BUF_ADDR_HI         2
`define BUF_SIZE_LO         3
`define BUF_SIZE_HI         4

// Writes to these two also fire a one-cycle command pulse
`define WRITE_BUF_UPDATE    5
`define RECORD_FORCE_FINISH 6

// Live status and readback window
`define TRACE_COUNT         7
`define TRACE_IDX           8
`define TRACE_WORD          9

`endif

//--- hdl/rr_pipe_reg.sv
`timescale 1ns/1ps

module rr_pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rstn,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t main_data;
    payload_t skid_data;
    logic main_valid;
    logic skid_valid;
    logic advance;

    // The main slot can take a new item when empty or when draining this cycle
    assign advance = ~main_valid | out_ready;

    // Ready depends only on local state, so no combinational path runs upstream
    assign in_ready = ~skid_valid;

    assign out_data = main_data;
    assign out_valid = main_valid;

    always_ff @(posedge clk) begin
        if (~rstn) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (advance) begin
            if (skid_valid) begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                main_valid <= in_valid;
            end
        end else if (in_valid && in_ready) begin
            // Main is stalled, park the item in the skid slot
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            main_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

//--- hdl/rr_pkg.sv
`include "rr_macros.svh"

package rr_pkg;

    // Fields driven by the AXI-lite master
    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Fields driven by the AXI-lite slave
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [3:0]  channel;
        logic [11:0] value;
    } log_entry_t;

    // The earlier entry sits in the low half
    typedef struct packed {
        log_entry_t hi;
        log_entry_t lo;
    } trace_word_t;

    typedef struct packed {
        logic [`RR_TRACE_AW-1:0] buf_addr;
        logic [`RR_TRACE_AW:0]   buf_size;
        logic                    write_buf_update;
        logic                    record_force_finish;
    } storage_csr_t;

    typedef struct packed {
        logic record_en;
        logic replay_en;
    } mode_csr_t;

    localparam log_entry_t pad_entry = '{channel: 4'hf, value: 12'h000};

endpackage

//--- hdl/rr_record_top.sv
`timescale 1ns/1ps
`include "rr_macros.svh"

module rr_record_top (
    input  logic               clk,
    input  logic               rstn,
    input  rr_pkg::axil_req_t  axil_req,
    output rr_pkg::axil_rsp_t  axil_rsp,
    input  rr_pkg::log_entry_t entry,
    input  logic               entry_valid,
    output logic               entry_ready
);

    rr_pkg::storage_csr_t storage_csr;
    rr_pkg::mode_csr_t mode_csr;

    logic [`RR_TRACE_AW:0] trace_count;
    logic [`RR_TRACE_AW-1:0] trace_rd_idx;
    rr_pkg::trace_word_t trace_rd_word;

    // Entry stage between the input stream and the packer
    rr_pkg::log_entry_t ent_data;
    logic ent_valid;
    logic ent_ready;

    // Packed words on their way to the ring buffer
    rr_pkg::trace_word_t pk_word;
    logic pk_valid;
    logic pk_ready;
    rr_pkg::trace_word_t wr_word;
    logic wr_valid;
    logic wr_ready;

    rr_csrs u_csrs (
        .clk           (clk),
        .rstn          (rstn),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .storage_csr   (storage_csr),
        .mode_csr      (mode_csr),
        .trace_count   (trace_count),
        .trace_rd_idx  (trace_rd_idx),
        .trace_rd_word (trace_rd_word)
    );

    rr_pipe_reg #(
        .payload_t (rr_pkg::log_entry_t)
    ) u_entry_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_data   (entry),
        .in_valid  (entry_valid),
        .in_ready  (entry_ready),
        .out_data  (ent_data),
        .out_valid (ent_valid),
        .out_ready (ent_ready)
    );

    rr_log_packer u_packer (
        .clk       (clk),
        .rstn      (rstn),
        .record_en (mode_csr.record_en),
        .flush     (storage_csr.record_force_finish),
        .in_entry  (ent_data),
        .in_valid  (ent_valid),
        .in_ready  (ent_ready),
        .out_word  (pk_word),
        .out_valid (pk_valid),
        .out_ready (pk_ready)
    );

    rr_pipe_reg #(
        .payload_t (rr_pkg::trace_word_t)
    ) u_word_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_data   (pk_word),
        .in_valid  (pk_valid),
        .in_ready  (pk_ready),
        .out_data  (wr_word),
        .out_valid (wr_valid),
        .out_ready (wr_ready)
    );

    rr_trace_writer u_writer (
        .clk           (clk),
        .rstn          (rstn),
        .storage_csr   (storage_csr),
        .in_word       (wr_word),
        .in_valid      (wr_valid),
        .in_ready      (wr_ready),
        .trace_count   (trace_count),
        .trace_rd_word (trace_rd_word),
        .trace_rd_idx  (trace_rd_idx)
    );

endmodule

//--- hdl/rr_trace_writer.sv
`timescale 1ns/1ps
`include "rr_macros.svh"

module rr_trace_writer (
    input  logic                    clk,
    input  logic                    rstn,
    input  rr_pkg::storage_csr_t    storage_csr,
    input  rr_pkg::trace_word_t     in_word,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic [`RR_TRACE_AW:0]   trace_count,
    output rr_pkg::trace_word_t     trace_rd_word,
    input  logic [`RR_TRACE_AW-1:0] trace_rd_idx
);

    localparam int unsigned DEPTH = 1 << `RR_TRACE_AW;

    rr_pkg::trace_word_t mem [DEPTH];

    logic [`RR_TRACE_AW-1:0] wr_ptr;
    logic [`RR_TRACE_AW:0]   wr_ptr_inc;
    logic [`RR_TRACE_AW:0]   count;
    logic [`RR_TRACE_AW-1:0] wr_addr;
    logic [`RR_TRACE_AW-1:0] rd_addr;
    logic accept;

    // Stop taking words once the ring is full, and during a buffer reset
    assign in_ready = (count < storage_csr.buf_size) & ~storage_csr.write_buf_update;
    assign accept = in_valid & in_ready;

    assign wr_ptr_inc = {1'b0, wr_ptr} + 1'b1;

    // The address sums wrap at the memory size
    assign wr_addr = storage_csr.buf_addr + wr_ptr;
    assign rd_addr = storage_csr.buf_addr + trace_rd_idx;

    always_ff @(posedge clk) begin
        if (~rstn) begin
            wr_ptr <= '0;
            count <= '0;
        end else if (storage_csr.write_buf_update) begin
            wr_ptr <= '0;
            count <= '0;
        end else if (accept) begin
            count <= count + 1'b1;
            if (wr_ptr_inc >= storage_csr.buf_size) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr_inc[`RR_TRACE_AW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_addr] <= in_word;
        end
    end

    assign trace_rd_word = mem[rd_addr];
    assign trace_count = count;

endmodule

//--- src.f
+incdir+hdl
hdl/rr_pkg.sv
hdl/rr_pipe_reg.sv
hdl/rr_log_packer.sv
hdl/rr_trace_writer.sv
hdl/rr_csrs.sv
hdl/rr_record_top.sv
verif/rr_record_tb.sv

//--- verif/rr_record_tb.sv
`timescale 1ns/1ps
`include "rr_macros.svh"

module rr_record_tb;

    // Several times the cycles that the directed tests take
    localparam int max_cycles = 4000;
    localparam int order_aw_first = 0;
    localparam int order_w_first = 1;
    localparam int order_same = 2;
    // Outputs are sampled this long after the falling edge, once they have settled
    localparam time settle = 1;

    localparam rr_pkg::log_entry_t pad_expected = '{channel: 4'hf, value: 12'h000};

    logic clk;
    logic rstn;
    rr_pkg::axil_req_t axil_req;
    rr_pkg::axil_rsp_t axil_rsp;
    rr_pkg::log_entry_t entry;
    logic entry_valid;
    logic entry_ready;

    int cycles = 0;
    rr_pkg::log_entry_t pushed [$];

    rr_record_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .entry       (entry),
        .entry_valid (entry_valid),
        .entry_ready (entry_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= max_cycles);
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped by the cycle limit");
    end

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic check_word(input rr_pkg::trace_word_t got, input rr_pkg::trace_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic check_count(input logic [`RR_TRACE_AW:0] got,
                               input logic [`RR_TRACE_AW:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    // Bytes with their strobe set take the new data, the rest keep the old value
    function automatic logic [31:0] strobe_merge(input logic [31:0] old_data,
                                                 input logic [31:0] new_data,
                                                 input logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? new_data[8*b +: 8] : old_data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic rr_pkg::log_entry_t random_entry();
        rr_pkg::log_entry_t e;
        e.channel = 4'($urandom);
        e.value = 12'($urandom);
        return e;
    endfunction

    task automatic axil_write(input int idx, input logic [31:0] data, input logic [3:0] strb,
                              input int order);
        bit aw_done;
        bit w_done;
        int delay;
        aw_done = 1'b0;
        w_done = 1'b0;
        delay = $urandom_range(0, 3);
        @(negedge clk);
        axil_req.awaddr = idx << 2;
        axil_req.wdata = data;
        axil_req.wstrb = strb;
        while (!(aw_done && w_done)) begin
            axil_req.awvalid = !aw_done && (order != order_w_first || w_done);
            axil_req.wvalid = !w_done && (order != order_aw_first || aw_done);
            #settle;
            aw_done = aw_done || (axil_req.awvalid && axil_rsp.awready);
            w_done = w_done || (axil_req.wvalid && axil_rsp.wready);
            @(negedge clk);
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        if (delay > 0) begin
            #settle;
            // While the response waits for bready, neither write channel is ready
            check_flag(axil_rsp.bvalid, 1'b1, "bvalid after both channels");
            check_flag(axil_rsp.awready, 1'b0, "awready with the response pending");
            check_flag(axil_rsp.wready, 1'b0, "wready with the response pending");
            repeat (delay) @(negedge clk);
        end
        axil_req.bready = 1'b1;
        #settle;
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
            #settle;
        end
        check_resp(axil_rsp.bresp, 2'b00, "bresp");
        @(negedge clk);
        axil_req.bready = 1'b0;
        #settle;
        // A second response here would mean the write was answered twice
        check_flag(axil_rsp.bvalid, 1'b0, "bvalid after the response");
    endtask

    task automatic axil_read(input int idx, output logic [31:0] data);
        int delay;
        delay = $urandom_range(0, 3);
        @(negedge clk);
        axil_req.araddr = idx << 2;
        axil_req.arvalid = 1'b1;
        #settle;
        while (!axil_rsp.arready) begin
            @(negedge clk);
            #settle;
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        if (delay > 0) begin
            #settle;
            check_flag(axil_rsp.rvalid, 1'b1, "rvalid one cycle after the address");
            check_flag(axil_rsp.arready, 1'b0, "arready with the read data pending");
            repeat (delay) @(negedge clk);
        end
        axil_req.rready = 1'b1;
        #settle;
        check_flag(axil_rsp.rvalid, 1'b1, "rvalid after the address");
        check_resp(axil_rsp.rresp, 2'b00, "rresp");
        data = axil_rsp.rdata;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic push_entry(input rr_pkg::log_entry_t e, input int max_wait, output bit taken);
        int waited;
        waited = 0;
        @(negedge clk);
        entry = e;
        entry_valid = 1'b1;
        #settle;
        while (!entry_ready && waited < max_wait) begin
            @(negedge clk);
            #settle;
            waited++;
        end
        taken = entry_ready;
        @(negedge clk);
        entry_valid = 1'b0;
    endtask

    task automatic push_random(input int n);
        rr_pkg::log_entry_t e;
        bit taken;
        for (int i = 0; i < n; i++) begin
            e = random_entry();
            push_entry(e, 50, taken);
            check_flag(taken, 1'b1, "entry accepted");
            pushed.push_back(e);
        end
    endtask

    // Points the ring at a region, empties it and turns recording on
    task automatic setup_ring(input int addr, input int size);
        axil_write(`BUF_ADDR_LO, addr, 4'hf, $urandom_range(0, 2));
        axil_write(`BUF_SIZE_LO, size, 4'hf, $urandom_range(0, 2));
        axil_write(`WRITE_BUF_UPDATE, 32'h1, 4'hf, order_same);
        axil_write(`RR_MODE, 32'h1, 4'hf, order_same);
        pushed.delete();
    endtask

    // Polls TRACE_COUNT while the pipeline drains
    task automatic wait_count(input int exp);
        logic [31:0] data;
        for (int i = 0; i < 30; i++) begin
            axil_read(`TRACE_COUNT, data);
            if (data == exp) begin
                break;
            end
        end
        check_count(data[`RR_TRACE_AW:0], exp[`RR_TRACE_AW:0], "TRACE_COUNT");
        check_data(data, exp, "TRACE_COUNT upper bits");
    endtask

    task automatic check_ring(input int first, input int n_words);
        logic [31:0] data;
        rr_pkg::trace_word_t exp;
        for (int k = 0; k < n_words; k++) begin
            exp.lo = pushed[first + 2*k];
            exp.hi = pushed[first + 2*k + 1];
            axil_write(`TRACE_IDX, k, 4'hf, order_same);
            axil_read(`TRACE_WORD, data);
            check_word(data, exp, "TRACE_WORD");
        end
    endtask

    task automatic test_reset_and_strobes();
        logic [3:0] strobes [3] = '{4'b0101, 4'b1000, 4'b0010};
        logic [31:0] data;
        logic [31:0] next;
        logic [31:0] exp;
        for (int i = 0; i < `RR_CSR_CNT; i++) begin
            // The readback window shows trace memory, which has no reset
            if (i != `TRACE_WORD) begin
                axil_read(i, data);
                check_data(data, 32'h0, "register after reset");
            end
        end
        exp = $urandom;
        axil_write(`BUF_ADDR_HI, exp, 4'hf, order_same);
        for (int i = 0; i < 3; i++) begin
            next = $urandom;
            axil_write(`BUF_ADDR_HI, next, strobes[i], order_same);
            exp = strobe_merge(exp, next, strobes[i]);
            axil_read(`BUF_ADDR_HI, data);
            check_data(data, exp, "BUF_ADDR_HI after a partial write");
        end
    endtask

    task automatic test_write_orders();
        int regs [3] = '{`BUF_ADDR_HI, `BUF_SIZE_HI, 11};
        logic [31:0] vals [3];
        logic [31:0] data;
        for (int i = 0; i < 3; i++) begin
            vals[i] = $urandom;
            axil_write(regs[i], vals[i], 4'hf, i);
        end
        for (int i = 0; i < 3; i++) begin
            axil_read(regs[i], data);
            check_data(data, vals[i], "stored register value");
        end
    endtask

    // Ten entries make five words, each pairing two entries in push order
    task automatic test_pairing();
        setup_ring(0, 32);
        push_random(10);
        wait_count(5);
        check_ring(0, 5);
    endtask

    task automatic test_flush_and_disable();
        logic [31:0] data;
        rr_pkg::trace_word_t exp;
        setup_ring(0, 32);
        push_random(3);
        axil_write(`RECORD_FORCE_FINISH, 32'h1, 4'hf, order_same);
        wait_count(2);
        check_ring(0, 1);
        exp.lo = pushed[2];
        exp.hi = pad_expected;
        axil_write(`TRACE_IDX, 1, 4'hf, order_same);
        axil_read(`TRACE_WORD, data);
        check_word(data, exp, "padded word");
        axil_write(`RR_MODE, 32'h0, 4'hf, order_same);
        push_random(4);
        repeat (10) @(negedge clk);
        axil_read(`TRACE_COUNT, data);
        check_count(data[`RR_TRACE_AW:0], 2, "TRACE_COUNT with recording off");
    endtask

    task automatic test_full_ring();
        rr_pkg::log_entry_t e;
        bit taken;
        bit stalled;
        int held;
        int words;
        setup_ring(0, 4);
        stalled = 1'b0;
        for (int i = 0; i < 24 && !stalled; i++) begin
            e = random_entry();
            push_entry(e, 20, taken);
            if (taken) begin
                pushed.push_back(e);
            end else begin
                stalled = 1'b1;
            end
        end
        check_flag(stalled, 1'b1, "entry_ready fell with the ring full");
        check_flag(pushed.size() > 8, 1'b1, "more than 8 entries accepted");
        wait_count(4);
        check_ring(0, 4);
        // Entries held back in the pipeline refill the ring from its start
        held = pushed.size() - 8;
        words = (held / 2 > 4) ? 4 : held / 2;
        axil_write(`WRITE_BUF_UPDATE, 32'h1, 4'hf, order_same);
        wait_count(words);
        check_ring(8, words);
    endtask

    task automatic test_offset_ring();
        // Offset 62 makes the region wrap past the end of trace memory
        setup_ring(62, 8);
        push_random(8);
        wait_count(4);
        check_ring(0, 4);
    endtask

    initial begin
        void'($urandom(32'h5bde_16a2));
        axil_req = '0;
        entry = '0;
        entry_valid = 1'b0;
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        test_reset_and_strobes();
        test_write_orders();
        test_pairing();
        test_flush_and_disable();
        test_full_ring();
        test_offset_ring();
        $display("Done: no errors");
        $finish;
    end

endmodule
